// File: Makefile
# Verilator simulation of the ROM access subsystem

VERILATOR ?= verilator
TOP       ?= jtkicker_rom_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/jtkicker_prog_swap.sv
`timescale 1ns/10ps

module jtkicker_prog_swap #(
    parameter int          ADDR_W    = jtkicker_rom_pkg::ADDR_W,
    parameter int unsigned SCR_START = jtkicker_rom_pkg::SCR_START_DEF,
    parameter int unsigned PCM_START = jtkicker_rom_pkg::PCM_START_DEF
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                prog_we,
    input  logic [ADDR_W-1:0]                   prog_addr,
    input  logic [jtkicker_rom_pkg::DATA_W-1:0] prog_data,
    output logic                                wr_en,
    output logic [ADDR_W-1:0]                   wr_addr,
    output logic [jtkicker_rom_pkg::DATA_W-1:0] wr_data
);

    logic in_scr;

    // Scroll tiles are stored with their nibbles reversed
    assign in_scr = (prog_addr >= SCR_START) && (prog_addr < PCM_START);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= prog_we;
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            wr_addr <= prog_addr;
            wr_data <= in_scr ? {prog_data[3:0], prog_data[7:4]} : prog_data;
        end
    end

endmodule

// File: source/jtkicker_rom_arb.sv
`timescale 1ns/10ps

module jtkicker_rom_arb #(
    parameter int ADDR_W    = jtkicker_rom_pkg::ADDR_W,
    parameter int N_CLIENTS = jtkicker_rom_pkg::N_CLIENTS,
    parameter int MEM_DEPTH = jtkicker_rom_pkg::MEM_DEPTH
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     downloading,
    input  logic [N_CLIENTS-1:0]                     req,
    input  logic [N_CLIENTS-1:0][ADDR_W-1:0]         req_addr,
    input  logic                                     credit_ret,
    output logic [N_CLIENTS-1:0]                     gnt,
    output logic                                     mem_req,
    output logic [ADDR_W-1:0]                        mem_addr,
    output logic [jtkicker_rom_pkg::ID_W-1:0]        mem_id
);

    localparam int ID_W  = jtkicker_rom_pkg::ID_W;
    localparam int CRD_W = $clog2(MEM_DEPTH + 1);

    logic [CRD_W-1:0] credits;
    logic [ID_W-1:0]  last_id;
    logic [ID_W-1:0]  pick;
    logic             found;
    logic             issue;

    // Round robin, search starts after the last winner
    always_comb begin : rr_pick
        int idx;
        found = 1'b0;
        pick  = '0;
        for (int i = 1; i <= N_CLIENTS; i++) begin
            idx = (int'(last_id) + i) % N_CLIENTS;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = ID_W'(idx);
            end
        end
    end

    // Download owns the memory
    assign issue    = found && (credits != '0) && !downloading;
    assign gnt      = issue ? (N_CLIENTS'(1) << pick) : '0;
    assign mem_req  = issue;
    assign mem_addr = req_addr[pick];
    assign mem_id   = pick;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRD_W'(MEM_DEPTH);
            last_id <= '0;
        end else begin
            case ({issue, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            if (issue) begin
                last_id <= pick;
            end
        end
    end

    // Memory never returns more credits than it was given
    assert property (@(posedge clk) disable iff (!arst_n) credits <= MEM_DEPTH);
    // A waiting slot keeps its request up until granted
    assert property (@(posedge clk) disable iff (!arst_n)
                     ($past(req & ~gnt) & ~req) == '0);

endmodule

// File: source/jtkicker_rom_mem.sv
`timescale 1ns/10ps

module jtkicker_rom_mem #(
    parameter int ADDR_W    = jtkicker_rom_pkg::ADDR_W,
    parameter int MEM_DEPTH = jtkicker_rom_pkg::MEM_DEPTH
) (
    input  logic                                clk,
    input  logic                                arst_n,
    // Download write port
    input  logic                                wr_en,
    input  logic [ADDR_W-1:0]                   wr_addr,
    input  logic [jtkicker_rom_pkg::DATA_W-1:0] wr_data,
    // Read requests
    input  logic                                mem_req,
    input  logic [ADDR_W-1:0]                   mem_addr,
    input  logic [jtkicker_rom_pkg::ID_W-1:0]   mem_id,
    output logic                                credit_ret,
    // Read responses
    output logic                                rsp_valid,
    output logic [jtkicker_rom_pkg::ID_W-1:0]   rsp_id,
    output logic [jtkicker_rom_pkg::DATA_W-1:0] rsp_data
);

    localparam int DATA_W = jtkicker_rom_pkg::DATA_W;
    localparam int ID_W   = jtkicker_rom_pkg::ID_W;
    localparam int LAT    = jtkicker_rom_pkg::MEM_LAT;
    localparam int PTR_W  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CNT_W  = $clog2(MEM_DEPTH + 1);

    logic [DATA_W-1:0] rom [0:(1 << ADDR_W) - 1];

    logic [ADDR_W-1:0] q_addr [0:MEM_DEPTH-1];
    logic [ID_W-1:0]   q_id   [0:MEM_DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    logic [LAT-1:0]    s_vld;
    logic [ID_W-1:0]   s_id   [0:LAT-1];
    logic [DATA_W-1:0] s_data [0:LAT-1];

    // One entry leaves the queue per cycle
    assign pop        = count != '0;
    assign credit_ret = pop;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            rom[wr_addr] <= wr_data;
        end
        if (mem_req) begin
            q_addr[wr_ptr] <= mem_addr;
            q_id[wr_ptr]   <= mem_id;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            s_vld  <= '0;
        end else begin
            if (mem_req) begin
                wr_ptr <= (wr_ptr == PTR_W'(MEM_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(MEM_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(mem_req) - CNT_W'(pop);
            s_vld <= {s_vld[LAT-2:0], pop};
        end
    end

    // Read pipeline, id travels with the data
    always_ff @(posedge clk) begin
        s_id[0]   <= q_id[rd_ptr];
        s_data[0] <= rom[q_addr[rd_ptr]];
        for (int k = 1; k < LAT; k++) begin
            s_id[k]   <= s_id[k-1];
            s_data[k] <= s_data[k-1];
        end
    end

    assign rsp_valid = s_vld[LAT-1];
    assign rsp_id    = s_id[LAT-1];
    assign rsp_data  = s_data[LAT-1];

    // Credits keep the queue from filling past its depth
    assert property (@(posedge clk) disable iff (!arst_n) mem_req |-> count < MEM_DEPTH);

endmodule

// File: source/jtkicker_rom_pkg.sv
package jtkicker_rom_pkg;

    // ROM byte address and data widths
    parameter int ADDR_W    = 16;
    parameter int DATA_W    = 8;

    // Read clients: main, sound, scroll and object
    parameter int N_CLIENTS = 4;
    parameter int ID_W      = (N_CLIENTS > 1) ? $clog2(N_CLIENTS) : 1;

    // Request queue depth, equal to the arbiter credits
    parameter int MEM_DEPTH = 4;

    // Cycles from queue pop to response
    parameter int MEM_LAT   = 3;

    // Scroll ROM region, nibbles swapped on download
    parameter int unsigned SCR_START_DEF = 32'h0000_4000;
    parameter int unsigned PCM_START_DEF = 32'h0000_8000;

endpackage

// File: source/jtkicker_rom_resp.sv
`timescale 1ns/10ps

module jtkicker_rom_resp #(
    parameter int N_CLIENTS = jtkicker_rom_pkg::N_CLIENTS
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                rsp_valid,
    input  logic [jtkicker_rom_pkg::ID_W-1:0]   rsp_id,
    input  logic [jtkicker_rom_pkg::DATA_W-1:0] rsp_data,
    output logic [N_CLIENTS-1:0]                fill,
    output logic [jtkicker_rom_pkg::DATA_W-1:0] fill_data
);

    // One-hot fill for the slot that asked
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill <= '0;
        end else begin
            fill <= rsp_valid ? (N_CLIENTS'(1) << rsp_id) : '0;
        end
    end

    // Data is shared by all slots
    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            fill_data <= rsp_data;
        end
    end

endmodule

// File: source/jtkicker_rom_slot.sv
`timescale 1ns/10ps

module jtkicker_rom_slot #(
    parameter int ADDR_W = jtkicker_rom_pkg::ADDR_W
) (
    input  logic                                clk,
    input  logic                                arst_n,
    // Client side
    input  logic                                rom_cs,
    input  logic [ADDR_W-1:0]                   rom_addr,
    output logic [jtkicker_rom_pkg::DATA_W-1:0] rom_data,
    output logic                                rom_ok,
    // Arbiter side
    output logic                                req,
    output logic [ADDR_W-1:0]                   req_addr,
    input  logic                                gnt,
    // Response router side
    input  logic                                fill,
    input  logic [jtkicker_rom_pkg::DATA_W-1:0] fill_data
);

    logic [ADDR_W-1:0] cache_addr;
    logic              valid;
    logic              pend;
    logic              hit;
    logic              launch;

    // A fill makes the fetched address the cached one
    always_comb begin
        if (fill) begin
            hit = rom_addr == req_addr;
        end else begin
            hit = valid && (rom_addr == cache_addr);
        end
    end

    assign launch = !req && !pend && rom_cs && !hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req    <= 1'b0;
            pend   <= 1'b0;
            valid  <= 1'b0;
            rom_ok <= 1'b0;
        end else begin
            rom_ok <= rom_cs && hit;
            if (fill) begin
                pend  <= 1'b0;
                valid <= 1'b1;
            end else if (req && gnt) begin
                req  <= 1'b0;
                pend <= 1'b1;
            end else if (launch) begin
                req   <= 1'b1;
                valid <= 1'b0;
            end
        end
    end

    // Cached data and address
    always_ff @(posedge clk) begin
        if (launch) begin
            req_addr <= rom_addr;
        end
        if (fill) begin
            cache_addr <= req_addr;
            rom_data   <= fill_data;
        end
    end

    // Router must only answer a granted request
    assert property (@(posedge clk) disable iff (!arst_n) fill |-> pend);

endmodule

// File: source/jtkicker_rom_top.sv
`timescale 1ns/10ps

module jtkicker_rom_top #(
    parameter int unsigned SCR_START = jtkicker_rom_pkg::SCR_START_DEF,
    parameter int unsigned PCM_START = jtkicker_rom_pkg::PCM_START_DEF,
    parameter int          N_CLIENTS = jtkicker_rom_pkg::N_CLIENTS,
    parameter int          MEM_DEPTH = jtkicker_rom_pkg::MEM_DEPTH,
    parameter int          ADDR_W    = jtkicker_rom_pkg::ADDR_W
) (
    input  logic                                                clk,
    input  logic                                                arst_n,
    // Download
    input  logic                                                downloading,
    input  logic                                                prog_we,
    input  logic [ADDR_W-1:0]                                   prog_addr,
    input  logic [jtkicker_rom_pkg::DATA_W-1:0]                 prog_data,
    // ROM clients
    input  logic [N_CLIENTS-1:0]                                rom_cs,
    input  logic [N_CLIENTS-1:0][ADDR_W-1:0]                    rom_addr,
    output logic [N_CLIENTS-1:0][jtkicker_rom_pkg::DATA_W-1:0]  rom_data,
    output logic [N_CLIENTS-1:0]                                rom_ok
);

    localparam int DATA_W = jtkicker_rom_pkg::DATA_W;
    localparam int ID_W   = jtkicker_rom_pkg::ID_W;

    logic                             wr_en;
    logic [ADDR_W-1:0]                wr_addr;
    logic [DATA_W-1:0]                wr_data;
    logic [N_CLIENTS-1:0]             req;
    logic [N_CLIENTS-1:0][ADDR_W-1:0] req_addr;
    logic [N_CLIENTS-1:0]             gnt;
    logic                             mem_req;
    logic [ADDR_W-1:0]                mem_addr;
    logic [ID_W-1:0]                  mem_id;
    logic                             credit_ret;
    logic                             rsp_valid;
    logic [ID_W-1:0]                  rsp_id;
    logic [DATA_W-1:0]                rsp_data;
    logic [N_CLIENTS-1:0]             fill;
    logic [DATA_W-1:0]                fill_data;

    jtkicker_prog_swap #(
        .ADDR_W    ( ADDR_W    ),
        .SCR_START ( SCR_START ),
        .PCM_START ( PCM_START )
    ) u_swap (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .prog_we   ( prog_we   ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .wr_en     ( wr_en     ),
        .wr_addr   ( wr_addr   ),
        .wr_data   ( wr_data   )
    );

    // One slot per client
    for (genvar i = 0; i < N_CLIENTS; i++) begin : g_slot
        jtkicker_rom_slot #(
            .ADDR_W    ( ADDR_W      )
        ) u_slot (
            .clk       ( clk         ),
            .arst_n    ( arst_n      ),
            .rom_cs    ( rom_cs[i]   ),
            .rom_addr  ( rom_addr[i] ),
            .rom_data  ( rom_data[i] ),
            .rom_ok    ( rom_ok[i]   ),
            .req       ( req[i]      ),
            .req_addr  ( req_addr[i] ),
            .gnt       ( gnt[i]      ),
            .fill      ( fill[i]     ),
            .fill_data ( fill_data   )
        );
    end

    jtkicker_rom_arb #(
        .ADDR_W      ( ADDR_W      ),
        .N_CLIENTS   ( N_CLIENTS   ),
        .MEM_DEPTH   ( MEM_DEPTH   )
    ) u_arb (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .req         ( req         ),
        .req_addr    ( req_addr    ),
        .credit_ret  ( credit_ret  ),
        .gnt         ( gnt         ),
        .mem_req     ( mem_req     ),
        .mem_addr    ( mem_addr    ),
        .mem_id      ( mem_id      )
    );

    jtkicker_rom_mem #(
        .ADDR_W     ( ADDR_W     ),
        .MEM_DEPTH  ( MEM_DEPTH  )
    ) u_mem (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .wr_en      ( wr_en      ),
        .wr_addr    ( wr_addr    ),
        .wr_data    ( wr_data    ),
        .mem_req    ( mem_req    ),
        .mem_addr   ( mem_addr   ),
        .mem_id     ( mem_id     ),
        .credit_ret ( credit_ret ),
        .rsp_valid  ( rsp_valid  ),
        .rsp_id     ( rsp_id     ),
        .rsp_data   ( rsp_data   )
    );

    jtkicker_rom_resp #(
        .N_CLIENTS ( N_CLIENTS )
    ) u_resp (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .rsp_valid ( rsp_valid ),
        .rsp_id    ( rsp_id    ),
        .rsp_data  ( rsp_data  ),
        .fill      ( fill      ),
        .fill_data ( fill_data )
    );

endmodule

// File: sources.f
source/jtkicker_rom_pkg.sv
source/jtkicker_prog_swap.sv
source/jtkicker_rom_slot.sv
source/jtkicker_rom_arb.sv
source/jtkicker_rom_mem.sv
source/jtkicker_rom_resp.sv
source/jtkicker_rom_top.sv
testbench/jtkicker_rom_tb.sv

// File: testbench/jtkicker_rom_tb.sv
`timescale 1ns/10ps

module jtkicker_rom_tb;

    localparam int          ADDR_W    = jtkicker_rom_pkg::ADDR_W;
    localparam int          DATA_W    = jtkicker_rom_pkg::DATA_W;
    localparam int          N_CLIENTS = jtkicker_rom_pkg::N_CLIENTS;
    localparam int          MEM_DEPTH = jtkicker_rom_pkg::MEM_DEPTH;
    // Moved away from the package defaults
    localparam int unsigned SCR_START = 32'h0000_6000;
    localparam int unsigned PCM_START = 32'h0000_A000;

    localparam int N_DL      = 1 << ADDR_W;
    localparam int ROUNDS    = 24;
    localparam int N_DIRECT  = 8;
    localparam int HOLD_CYC  = 12;
    localparam int STALL_CYC = 10;
    localparam int OK_LIMIT  = 200;
    localparam int N_READS   = 4 + 2 * N_DIRECT + N_CLIENTS * ROUNDS + 4 + N_CLIENTS;
    localparam int CYC_BOUND = 8;
    localparam int CLK_NS    = 8;
    localparam int WATCH_NS  = (N_DL + N_READS) * CYC_BOUND * CLK_NS;

    logic                             clk;
    logic                             arst_n;
    logic                             downloading;
    logic                             prog_we;
    logic [ADDR_W-1:0]                prog_addr;
    logic [DATA_W-1:0]                prog_data;
    logic [N_CLIENTS-1:0]             rom_cs;
    logic [N_CLIENTS-1:0][ADDR_W-1:0] rom_addr;
    logic [N_CLIENTS-1:0][DATA_W-1:0] rom_data;
    logic [N_CLIENTS-1:0]             rom_ok;

    logic [DATA_W-1:0] dl_image  [0:N_DL-1];
    logic [ADDR_W-1:0] rnd_addr  [0:N_CLIENTS-1][0:ROUNDS-1];
    logic [ADDR_W-1:0] seen_addr [0:N_CLIENTS-1];
    logic              seen_cs   [0:N_CLIENTS-1];
    integer            seed;

    jtkicker_rom_top #(
        .SCR_START   ( SCR_START   ),
        .PCM_START   ( PCM_START   ),
        .N_CLIENTS   ( N_CLIENTS   ),
        .MEM_DEPTH   ( MEM_DEPTH   ),
        .ADDR_W      ( ADDR_W      )
    ) UUT (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .prog_we     ( prog_we     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .rom_cs      ( rom_cs      ),
        .rom_addr    ( rom_addr    ),
        .rom_data    ( rom_data    ),
        .rom_ok      ( rom_ok      )
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Byte the ROM should hold after download
    function automatic logic [DATA_W-1:0] expected_byte(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] raw;
        int unsigned       a;
        raw = dl_image[addr];
        a   = 32'(addr);
        if (a >= SCR_START && a < PCM_START) begin
            return {raw[3:0], raw[7:4]};
        end
        return raw;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input int c, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time %0t rom_data[%0d] got %02h expected %02h",
                                    $time, c, got, exp));
        end
    endtask

    task automatic check_ok(input int c, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time %0t rom_ok[%0d] got %b expected %b",
                                    $time, c, got, exp));
        end
    endtask

    // rom_ok at a falling edge belongs to the address of the edge before
    always @(negedge clk) begin
        for (int c = 0; c < N_CLIENTS; c++) begin
            if (arst_n && rom_ok[c]) begin
                if (!seen_cs[c]) begin
                    stop_on_error($sformatf("client %0d shows rom_ok without rom_cs", c));
                end
                check_data(c, rom_data[c], expected_byte(seen_addr[c]));
            end
            seen_addr[c] = rom_addr[c];
            seen_cs[c]   = rom_cs[c];
        end
    end

    initial begin
        #(WATCH_NS);
        stop_on_error($sformatf("watchdog expired after %0d ns, the test did not finish",
                                WATCH_NS));
    end

    task automatic download_image();
        @(posedge clk);
        downloading <= 1'b1;
        for (int a = 0; a < N_DL; a++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= ADDR_W'(a);
            prog_data <= dl_image[a];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        // Last write lands one cycle later
        @(posedge clk);
        downloading <= 1'b0;
    endtask

    task automatic drive_read(input int c, input logic [ADDR_W-1:0] addr);
        @(posedge clk);
        rom_cs[c]   <= 1'b1;
        rom_addr[c] <= addr;
    endtask

    task automatic wait_ok(input int c);
        int n;
        n = 0;
        @(negedge clk);
        while (!rom_ok[c]) begin
            if (n == OK_LIMIT) begin
                stop_on_error($sformatf("client %0d got no rom_ok within %0d cycles",
                                        c, OK_LIMIT));
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    // First falling edge still shows the old address
    task automatic read_once(input int c, input logic [ADDR_W-1:0] addr);
        drive_read(c, addr);
        @(negedge clk);
        wait_ok(c);
    endtask

    task automatic region_reads(input bit in_region);
        logic [ADDR_W-1:0] addr;
        int unsigned       span;
        for (int k = 0; k < N_DIRECT; k++) begin
            if (in_region) begin
                span = PCM_START - SCR_START;
                addr = ADDR_W'(SCR_START + $unsigned($random(seed)) % span);
            end else if (k % 2 == 0) begin
                addr = ADDR_W'($unsigned($random(seed)) % SCR_START);
            end else begin
                span = N_DL - PCM_START;
                addr = ADDR_W'(PCM_START + $unsigned($random(seed)) % span);
            end
            read_once(k % N_CLIENTS, addr);
        end
    endtask

    task automatic run_client(input int c);
        for (int r = 0; r < ROUNDS; r++) begin
            read_once(c, rnd_addr[c][r]);
            repeat (r % 3) @(negedge clk);
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        rom_cs      = '0;
        rom_addr    = '0;
        seed        = 80432;
        for (int a = 0; a < N_DL; a++) begin
            dl_image[a] = DATA_W'($random(seed));
        end
        for (int c = 0; c < N_CLIENTS; c++) begin
            for (int r = 0; r < ROUNDS; r++) begin
                rnd_addr[c][r] = ADDR_W'($random(seed));
            end
        end

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Nothing selected, nothing ready
        repeat (4) begin
            @(negedge clk);
            for (int c = 0; c < N_CLIENTS; c++) begin
                check_ok(c, rom_ok[c], 1'b0);
            end
        end

        download_image();

        // Edges of the scroll region
        read_once(0, ADDR_W'(SCR_START - 1));
        read_once(1, ADDR_W'(SCR_START));
        read_once(2, ADDR_W'(PCM_START - 1));
        read_once(3, ADDR_W'(PCM_START));
        region_reads(1'b0);
        region_reads(1'b1);

        fork
            run_client(0);
            run_client(1);
            run_client(2);
            run_client(3);
        join

        // Held address, then a move to the next byte
        read_once(1, rnd_addr[1][0]);
        repeat (HOLD_CYC) begin
            @(negedge clk);
            check_ok(1, rom_ok[1], 1'b1);
        end
        drive_read(1, rnd_addr[1][0] + ADDR_W'(1));
        @(negedge clk);
        @(negedge clk);
        check_ok(1, rom_ok[1], 1'b0);
        wait_ok(1);

        // Address moves while the first fetch is in flight
        drive_read(2, rnd_addr[2][1]);
        drive_read(2, rnd_addr[2][2]);
        @(negedge clk);
        wait_ok(2);

        // Requests wait while the download owns the memory
        @(posedge clk);
        downloading <= 1'b1;
        for (int c = 0; c < N_CLIENTS; c++) begin
            rom_addr[c] <= ~rom_addr[c];
        end
        @(negedge clk);
        repeat (STALL_CYC) begin
            @(negedge clk);
            for (int c = 0; c < N_CLIENTS; c++) begin
                check_ok(c, rom_ok[c], 1'b0);
            end
        end
        @(posedge clk);
        downloading <= 1'b0;
        for (int c = 0; c < N_CLIENTS; c++) begin
            wait_ok(c);
        end

        // Deselect drops rom_ok
        @(posedge clk);
        rom_cs <= '0;
        @(negedge clk);
        @(negedge clk);
        for (int c = 0; c < N_CLIENTS; c++) begin
            check_ok(c, rom_ok[c], 1'b0);
        end

        repeat (4) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
